// ==== verilog/stm_pkg.sv ====
package stm_pkg;

  // ************************************************************************
  // sizes
  // ************************************************************************

  localparam int NUM_SEGMENT = 2;
  localparam int NUM_TRANS = 16;
  localparam int TRANS_W = 4;
  localparam int IDX_W = 4;                 // up to 16 patterns per segment
  localparam logic [7:0] REP_INFINITE = 8'hff;

  localparam int RAM_ADDR_W = 1 + IDX_W + TRANS_W;  // {segment, idx, trans}
  localparam int RAM_DEPTH = NUM_SEGMENT * (2 ** IDX_W) * NUM_TRANS;
  localparam int FIFO_DEPTH = 4;

  // ************************************************************************
  // grouped signals
  // ************************************************************************

  typedef struct packed {
    logic [7:0] intensity;
    logic [7:0] phase;
    logic [TRANS_W-1:0] trans;
    logic segment;
  } drive_t;                                // 21 bits

  typedef struct packed {
    logic en;
    logic segment;
    logic [IDX_W-1:0] idx;
    logic [TRANS_W-1:0] trans;
    logic [7:0] intensity;
    logic [7:0] phase;
  } pattern_wr_t;

  typedef struct packed {
    logic en;
    logic segment;
    logic [TRANS_W-1:0] trans;
    logic keep;                             // 1 = transducer drives
  } mask_wr_t;

  typedef struct packed {
    logic [NUM_SEGMENT-1:0][IDX_W-1:0] cycle;  // pattern count with 0 for 16
    logic [NUM_SEGMENT-1:0][7:0] freq_div;     // clocks per pattern step
    logic req_segment;
    logic [7:0] rep;
  } stm_settings_t;

endpackage

// ==== verilog/stm_timer.sv ====
`timescale 1ns/10ps

module stm_timer
  import stm_pkg::*;
(
  input  logic CLK,
  input  logic arst_n,
  input  logic settings_update,
  input  logic [NUM_SEGMENT-1:0][IDX_W-1:0] cycle,
  input  logic [NUM_SEGMENT-1:0][7:0] freq_div,
  output logic [NUM_SEGMENT-1:0][IDX_W-1:0] idx,
  output logic [NUM_SEGMENT-1:0] wrap
);

  logic [NUM_SEGMENT-1:0][IDX_W-1:0] cycle_q;
  logic [NUM_SEGMENT-1:0][7:0] freq_div_q;
  logic [NUM_SEGMENT-1:0][7:0] div_cnt;
  logic [NUM_SEGMENT-1:0] step;

  always_comb begin
    for (int s = 0; s < NUM_SEGMENT; s++) begin
      step[s] = (div_cnt[s] == freq_div_q[s] - 8'd1);
      // 4-bit wrap compare lets cycle 0 run all 16 patterns
      wrap[s] = step[s] && (idx[s] == cycle_q[s] - 1'b1) && !settings_update;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      cycle_q <= '0;
      freq_div_q <= {NUM_SEGMENT{8'd1}};
      div_cnt <= '0;
      idx <= '0;
    end else if (settings_update) begin
      cycle_q <= cycle;
      freq_div_q <= freq_div;
      div_cnt <= '0;                        // restart all segments together
      idx <= '0;
    end else begin
      for (int s = 0; s < NUM_SEGMENT; s++) begin
        if (step[s]) begin
          div_cnt[s] <= '0;
          if (wrap[s]) begin
            idx[s] <= '0;
          end else begin
            idx[s] <= idx[s] + 1'b1;
          end
        end else begin
          div_cnt[s] <= div_cnt[s] + 8'd1;
        end
      end
    end
  end

endmodule

// ==== verilog/stm_segment_ctrl.sv ====
`timescale 1ns/10ps

module stm_segment_ctrl
  import stm_pkg::*;
(
  input  logic CLK,
  input  logic arst_n,
  input  logic settings_update,
  input  logic req_segment,
  input  logic [7:0] rep,
  input  logic [NUM_SEGMENT-1:0][IDX_W-1:0] idx,
  input  logic [NUM_SEGMENT-1:0] wrap,
  output logic segment,
  output logic [IDX_W-1:0] cur_idx,
  output logic stop
);

  logic pending;
  logic [7:0] rep_q;
  logic [7:0] rep_cnt;
  logic swap;
  logic count_wrap;

  assign cur_idx = idx[segment];

  // swap only when the requested segment rolls over to 0
  assign swap = (pending != segment) && wrap[pending];
  assign count_wrap = wrap[segment] && !stop;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      pending <= 1'b0;
      segment <= 1'b0;
      rep_q <= REP_INFINITE;
      rep_cnt <= '0;
      stop <= 1'b0;
    end else if (settings_update) begin
      pending <= req_segment;
      rep_q <= rep;
    end else if (swap) begin
      segment <= pending;
      rep_cnt <= '0;                        // fresh budget for the new segment
      stop <= 1'b0;
    end else if (count_wrap) begin
      rep_cnt <= rep_cnt + 8'd1;
      // this wrap makes the count rep + 1
      if (rep_q != REP_INFINITE && rep_cnt == rep_q) begin
        stop <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/stm_pattern_ram.sv ====
`timescale 1ns/10ps

module stm_pattern_ram
  import stm_pkg::*;
(
  input  logic CLK,
  input  pattern_wr_t pattern_wr,
  input  logic rd_segment,
  input  logic [IDX_W-1:0] rd_idx,
  input  logic [TRANS_W-1:0] rd_trans,
  output logic [7:0] rd_intensity,
  output logic [7:0] rd_phase
);

  logic [15:0] mem [RAM_DEPTH];             // {intensity, phase}
  logic [RAM_ADDR_W-1:0] wr_addr;
  logic [RAM_ADDR_W-1:0] rd_addr;
  logic [15:0] rd_q;

  assign wr_addr = {pattern_wr.segment, pattern_wr.idx, pattern_wr.trans};
  assign rd_addr = {rd_segment, rd_idx, rd_trans};

  always_ff @(posedge CLK) begin
    if (pattern_wr.en) begin
      mem[wr_addr] <= {pattern_wr.intensity, pattern_wr.phase};
    end
  end

  // one cycle read latency
  always_ff @(posedge CLK) begin
    rd_q <= mem[rd_addr];
  end

  assign rd_intensity = rd_q[15:8];
  assign rd_phase = rd_q[7:0];

endmodule

// ==== verilog/stm_pattern_reader.sv ====
`timescale 1ns/10ps

module stm_pattern_reader
  import stm_pkg::*;
(
  input  logic CLK,
  input  logic arst_n,
  input  logic start,
  input  logic segment,
  input  logic [IDX_W-1:0] idx,
  input  logic ack,
  input  pattern_wr_t pattern_wr,
  output logic busy,
  output logic req,
  output drive_t data
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_OFFER,
    ST_RELEASE
  } state_t;

  state_t state;
  logic seg_q;
  logic [IDX_W-1:0] idx_q;
  logic [TRANS_W-1:0] trans_q;
  logic [7:0] rd_intensity;
  logic [7:0] rd_phase;

  stm_pattern_ram stm_pattern_ram (
    .CLK(CLK),
    .pattern_wr(pattern_wr),
    .rd_segment(seg_q),
    .rd_idx(idx_q),
    .rd_trans(trans_q),
    .rd_intensity(rd_intensity),
    .rd_phase(rd_phase)
  );

  // RAM address holds until ack drops, so the word stays put while offered
  assign data = '{intensity: rd_intensity, phase: rd_phase, trans: trans_q, segment: seg_q};
  assign busy = start || (state != ST_IDLE);

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
      seg_q <= 1'b0;
      idx_q <= '0;
      trans_q <= '0;
      req <= 1'b0;
    end else begin
      case (state)
        ST_IDLE: if (start) begin
          seg_q <= segment;
          idx_q <= idx;
          trans_q <= '0;
          state <= ST_READ;
        end
        ST_READ: begin
          req <= 1'b1;                      // RAM word valid next cycle
          state <= ST_OFFER;
        end
        ST_OFFER: if (ack) begin
          req <= 1'b0;
          state <= ST_RELEASE;
        end
        ST_RELEASE: if (!ack) begin
          if (trans_q == TRANS_W'(NUM_TRANS - 1)) begin
            state <= ST_IDLE;               // frame done
          end else begin
            trans_q <= trans_q + 1'b1;
            state <= ST_READ;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

// ==== verilog/drive_fifo.sv ====
`timescale 1ns/10ps

module drive_fifo
  import stm_pkg::*;
#(
  parameter type T = drive_t,
  parameter int DEPTH = FIFO_DEPTH
) (
  input  logic CLK,
  input  logic arst_n,
  input  logic in_req,
  input  T in_data,
  input  logic out_ack,
  output logic in_ack,
  output logic out_req,
  output T out_data
);

  T mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic [$clog2(DEPTH+1)-1:0] count;
  logic full;
  logic push;
  logic pop;
  logic out_ack_q;

  assign full = (count == DEPTH);
  assign push = in_req && !in_ack && !full; // full keeps in_ack low
  assign pop = out_ack_q && !out_ack;       // falling ack retires the head
  assign out_data = mem[rd_ptr];

  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      in_ack <= 1'b0;
      out_req <= 1'b0;
      out_ack_q <= 1'b0;
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      out_ack_q <= out_ack;
      if (push) begin
        in_ack <= 1'b1;
        wr_ptr <= (wr_ptr == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
      end else if (in_ack && !in_req) begin
        in_ack <= 1'b0;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
      // next offer waits until the previous pop has settled
      if (out_req && out_ack) begin
        out_req <= 1'b0;
      end else if (!out_req && !out_ack && !out_ack_q && count != 0) begin
        out_req <= 1'b1;
      end
    end
  end

endmodule

// ==== verilog/output_mask.sv ====
`timescale 1ns/10ps

module output_mask
  import stm_pkg::*;
(
  input  logic CLK,
  input  logic arst_n,
  input  mask_wr_t mask_wr,
  input  logic req,
  input  drive_t data,
  output logic ack,
  output logic [7:0] intensity,
  output logic [7:0] phase,
  output logic dout_valid
);

  logic [NUM_SEGMENT-1:0][NUM_TRANS-1:0] mask_bits;
  drive_t word_q;
  logic accept;
  logic taken;

  assign accept = req && !ack;

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      mask_bits <= '1;                      // everything drives by default
      ack <= 1'b0;
      taken <= 1'b0;
      dout_valid <= 1'b0;
    end else begin
      if (mask_wr.en) begin
        mask_bits[mask_wr.segment][mask_wr.trans] <= mask_wr.keep;
      end
      if (accept) begin
        ack <= 1'b1;
      end else if (ack && !req) begin
        ack <= 1'b0;
      end
      taken <= accept;
      dout_valid <= taken;                  // one cycle after ack rises
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      word_q <= data;
    end
    if (taken) begin
      if (mask_bits[word_q.segment][word_q.trans]) begin
        intensity <= word_q.intensity;
        phase <= word_q.phase;
      end else begin
        intensity <= '0;                    // silenced transducer
        phase <= '0;
      end
    end
  end

endmodule

// ==== verilog/stm_top.sv ====
`timescale 1ns/10ps

module stm_top
  import stm_pkg::*;
(
  input  logic CLK,
  input  logic arst_n,
  input  stm_settings_t settings,
  input  logic settings_update,
  input  logic update,
  input  pattern_wr_t pattern_wr,
  input  mask_wr_t mask_wr,
  output logic [7:0] intensity,
  output logic [7:0] phase,
  output logic dout_valid,
  output logic [IDX_W-1:0] debug_idx,
  output logic debug_segment
);

  logic [NUM_SEGMENT-1:0][IDX_W-1:0] timer_idx;
  logic [NUM_SEGMENT-1:0] timer_wrap;
  logic active_segment;
  logic [IDX_W-1:0] active_idx;
  logic stop;
  logic start;
  logic busy;
  logic frame_segment;
  logic [IDX_W-1:0] frame_idx;
  logic in_req;
  logic in_ack;
  drive_t in_data;
  logic out_req;
  logic out_ack;
  drive_t out_data;

  assign debug_idx = frame_idx;
  assign debug_segment = frame_segment;

  // ************************************************************************
  // pattern index and segment selection
  // ************************************************************************

  stm_timer stm_timer (
    .CLK(CLK),
    .arst_n(arst_n),
    .settings_update(settings_update),
    .cycle(settings.cycle),
    .freq_div(settings.freq_div),
    .idx(timer_idx),
    .wrap(timer_wrap)
  );

  stm_segment_ctrl stm_segment_ctrl (
    .CLK(CLK),
    .arst_n(arst_n),
    .settings_update(settings_update),
    .req_segment(settings.req_segment),
    .rep(settings.rep),
    .idx(timer_idx),
    .wrap(timer_wrap),
    .segment(active_segment),
    .cur_idx(active_idx),
    .stop(stop)
  );

  // ************************************************************************
  // frame latch that ignores update while a frame is in flight
  // ************************************************************************

  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      start <= 1'b0;
      frame_segment <= 1'b0;
      frame_idx <= '0;
    end else begin
      start <= update && !busy;
      if (update && !busy && !stop) begin
        frame_segment <= active_segment;
        frame_idx <= active_idx;            // frozen while stopped
      end
    end
  end

  // ************************************************************************
  // readout path
  // ************************************************************************

  stm_pattern_reader stm_pattern_reader (
    .CLK(CLK),
    .arst_n(arst_n),
    .start(start),
    .segment(frame_segment),
    .idx(frame_idx),
    .ack(in_ack),
    .pattern_wr(pattern_wr),
    .busy(busy),
    .req(in_req),
    .data(in_data)
  );

  drive_fifo #(
    .T(drive_t),
    .DEPTH(FIFO_DEPTH)
  ) drive_fifo (
    .CLK(CLK),
    .arst_n(arst_n),
    .in_req(in_req),
    .in_data(in_data),
    .out_ack(out_ack),
    .in_ack(in_ack),
    .out_req(out_req),
    .out_data(out_data)
  );

  output_mask output_mask (
    .CLK(CLK),
    .arst_n(arst_n),
    .mask_wr(mask_wr),
    .req(out_req),
    .data(out_data),
    .ack(out_ack),
    .intensity(intensity),
    .phase(phase),
    .dout_valid(dout_valid)
  );

endmodule

// ==== test/tb_stm_model.svh ====
`ifndef TB_STM_MODEL_SVH
`define TB_STM_MODEL_SVH

typedef struct packed {
  logic seg;
  logic [IDX_W-1:0] idx;
  logic [TRANS_W-1:0] trans;
} exp_word_t;

exp_word_t exp_q[$];                        // words still owed by the DUT
logic [15:0] shadow_ram [NUM_SEGMENT][2**IDX_W][NUM_TRANS];
logic shadow_mask [NUM_SEGMENT][NUM_TRANS];

int m_cycle [NUM_SEGMENT];
int m_div [NUM_SEGMENT];
int m_div_cnt [NUM_SEGMENT];
int m_idx [NUM_SEGMENT];
logic m_pending;
logic m_segment;
logic [7:0] m_rep;
int m_rep_cnt;                              // wraps since the last swap
logic m_stop;
logic m_frame_seg;
int m_frame_idx;

function automatic logic [15:0] expected_drive(input logic seg, input int idx, input int trans);
  if (!shadow_mask[seg][trans]) begin
    return 16'h0000;                        // silenced in this segment only
  end
  return shadow_ram[seg][idx][trans];
endfunction

task automatic model_reset();
  for (int s = 0; s < NUM_SEGMENT; s++) begin
    m_cycle[s] = 16;
    m_div[s] = 1;
    m_div_cnt[s] = 0;
    m_idx[s] = 0;
    for (int t = 0; t < NUM_TRANS; t++) begin
      shadow_mask[s][t] = 1'b1;
    end
  end
  m_pending = 1'b0;
  m_segment = 1'b0;
  m_rep = REP_INFINITE;
  m_rep_cnt = 0;
  m_stop = 1'b0;
  m_frame_seg = 1'b0;
  m_frame_idx = 0;
  exp_q.delete();
endtask

// one clock edge with all decisions taken on the values before the edge
task automatic model_step();
  logic [NUM_SEGMENT-1:0] m_step;
  logic [NUM_SEGMENT-1:0] m_wrap;
  if (update && exp_q.size() == 0) begin
    if (!m_stop) begin
      m_frame_seg = m_segment;
      m_frame_idx = m_idx[m_segment];
    end
    for (int t = 0; t < NUM_TRANS; t++) begin
      exp_q.push_back('{seg: m_frame_seg, idx: IDX_W'(m_frame_idx), trans: TRANS_W'(t)});
    end
  end
  for (int s = 0; s < NUM_SEGMENT; s++) begin
    m_step[s] = (m_div_cnt[s] == m_div[s] - 1);
    m_wrap[s] = m_step[s] && (m_idx[s] == m_cycle[s] - 1) && !settings_update;
  end
  if (settings_update) begin
    m_pending = settings.req_segment;
    m_rep = settings.rep;
  end else if (m_pending != m_segment && m_wrap[m_pending]) begin
    m_segment = m_pending;
    m_rep_cnt = 0;
    m_stop = 1'b0;
  end else if (m_wrap[m_segment] && !m_stop) begin
    m_rep_cnt++;
    if (m_rep != REP_INFINITE && m_rep_cnt == int'(m_rep) + 1) begin
      m_stop = 1'b1;
    end
  end
  for (int s = 0; s < NUM_SEGMENT; s++) begin
    if (settings_update) begin
      m_cycle[s] = (settings.cycle[s] == 0) ? 16 : int'(settings.cycle[s]);
      m_div[s] = int'(settings.freq_div[s]);
      m_div_cnt[s] = 0;
      m_idx[s] = 0;
    end else if (m_step[s]) begin
      m_div_cnt[s] = 0;
      m_idx[s] = m_wrap[s] ? 0 : m_idx[s] + 1;
    end else begin
      m_div_cnt[s]++;
    end
  end
endtask

`endif

// ==== test/tb_stm.sv ====
`timescale 1ns/10ps

module tb_stm
  import stm_pkg::*;
();

  localparam time CLK_PERIOD = 4ns;
  localparam time DRIVE_DELAY = 1ns;
  localparam int RESET_CYCLES = 4;
  localparam int NUM_FRAMES = 46;
  localparam int FRAME_LIMIT = NUM_TRANS * 20;
  localparam int SETTLE_CYCLES = 3000;      // memory fill, settings and gaps

  logic CLK;
  logic arst_n;
  stm_settings_t settings;
  logic settings_update;
  logic update;
  pattern_wr_t pattern_wr;
  mask_wr_t mask_wr;
  logic [7:0] intensity;
  logic [7:0] phase;
  logic dout_valid;
  logic [IDX_W-1:0] debug_idx;
  logic debug_segment;

  int seed = 4313;
  int errors = 0;
  int checks = 0;
  int frames = 0;

  `include "tb_stm_model.svh"

  stm_top dut (
    .CLK(CLK),
    .arst_n(arst_n),
    .settings(settings),
    .settings_update(settings_update),
    .update(update),
    .pattern_wr(pattern_wr),
    .mask_wr(mask_wr),
    .intensity(intensity),
    .phase(phase),
    .dout_valid(dout_valid),
    .debug_idx(debug_idx),
    .debug_segment(debug_segment)
  );

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  initial begin
    #((NUM_FRAMES * FRAME_LIMIT + SETTLE_CYCLES) * CLK_PERIOD);
    $display("watchdog timed out, the run did not finish in time");
    $display("FAIL: see errors above");
    $finish;
  end

  // ************************************************************************
  // model and comparator
  // ************************************************************************

  always @(posedge CLK) begin
    if (!arst_n) begin
      model_reset();
    end else begin
      model_step();
    end
  end

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  always @(posedge CLK) begin
    exp_word_t w;
    if (arst_n && dout_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("ERROR at %0t: output word with no frame outstanding", $time);
      end else begin
        w = exp_q.pop_front();
        check({intensity, phase}, expected_drive(w.seg, w.idx, w.trans),
              $sformatf("seg %0d idx %0d trans %0d", w.seg, w.idx, w.trans));
      end
    end
  end

  // ************************************************************************
  // stimulus
  // ************************************************************************

  task automatic write_pattern(input int seg, input int idx, input int trans);
    logic [15:0] word;
    word = $random(seed);
    @(posedge CLK);
    #DRIVE_DELAY;
    pattern_wr = '{en: 1'b1, segment: seg[0], idx: IDX_W'(idx), trans: TRANS_W'(trans),
                   intensity: word[15:8], phase: word[7:0]};
    shadow_ram[seg][idx][trans] = word;
  endtask

  task automatic fill_patterns();
    for (int s = 0; s < NUM_SEGMENT; s++) begin
      for (int i = 0; i < 2 ** IDX_W; i++) begin
        for (int t = 0; t < NUM_TRANS; t++) begin
          write_pattern(s, i, t);
        end
      end
    end
    @(posedge CLK);
    #DRIVE_DELAY;
    pattern_wr = '0;
  endtask

  task automatic write_mask(input int seg, input int trans, input logic keep);
    @(posedge CLK);
    #DRIVE_DELAY;
    mask_wr = '{en: 1'b1, segment: seg[0], trans: TRANS_W'(trans), keep: keep};
    shadow_mask[seg][trans] = keep;
    @(posedge CLK);
    #DRIVE_DELAY;
    mask_wr = '0;
  endtask

  task automatic apply_settings(input int c0, input int c1, input int d0, input int d1,
                                input logic req, input logic [7:0] rep);
    @(posedge CLK);
    #DRIVE_DELAY;
    settings.cycle[0] = IDX_W'(c0 % 16);    // 16 patterns encode as 0
    settings.cycle[1] = IDX_W'(c1 % 16);
    settings.freq_div[0] = 8'(d0);
    settings.freq_div[1] = 8'(d1);
    settings.req_segment = req;
    settings.rep = rep;
    settings_update = 1'b1;
    @(posedge CLK);
    #DRIVE_DELAY;
    settings_update = 1'b0;
  endtask

  // update stays high for extra edges that land on a busy reader
  task automatic run_frame(input int dropped, input int gap);
    int waited;
    @(posedge CLK);
    #DRIVE_DELAY;
    update = 1'b1;
    repeat (dropped + 1) @(posedge CLK);
    #DRIVE_DELAY;
    update = 1'b0;
    waited = 0;
    while (exp_q.size() != 0 && waited < FRAME_LIMIT) begin
      @(posedge CLK);
      #DRIVE_DELAY;
      waited++;
    end
    if (exp_q.size() != 0) begin
      errors++;
      $display("frame %0d did not complete within %0d cycles", frames, FRAME_LIMIT);
      exp_q.delete();
    end
    check(32'(debug_segment), 32'(m_frame_seg), "frame segment");
    check(32'(debug_idx), 32'(m_frame_idx), "frame index");
    frames++;
    repeat (gap) @(posedge CLK);
  endtask

  initial begin
    arst_n = 1'b0;
    settings = '0;
    settings_update = 1'b0;
    update = 1'b0;
    pattern_wr = '0;
    mask_wr = '0;
    repeat (RESET_CYCLES) @(posedge CLK);
    #DRIVE_DELAY;
    arst_n = 1'b1;

    apply_settings(16, 16, 1, 1, 1'b0, REP_INFINITE);    // plain readout
    fill_patterns();
    repeat (6) run_frame(0, 0);

    apply_settings(5, 16, 7, 1, 1'b0, REP_INFINITE);     // index stepping
    for (int i = 0; i < 6; i++) begin
      run_frame(0, i * 3);
    end
    apply_settings(3, 16, 40, 1, 1'b0, REP_INFINITE);
    repeat (6) run_frame(0, 0);

    apply_settings(3, 4, 40, 60, 1'b1, REP_INFINITE);    // swap on segment 1 wrap
    repeat (8) run_frame(0, 5);

    apply_settings(5, 4, 3, 60, 1'b0, 8'd1);             // stop after two wraps
    repeat (6) run_frame(0, 0);
    apply_settings(5, 4, 3, 5, 1'b1, REP_INFINITE);
    repeat (6) run_frame(0, 7);

    write_mask(1, 3, 1'b0);
    write_mask(1, 7, 1'b0);
    write_mask(1, 12, 1'b0);
    write_mask(0, 5, 1'b0);
    repeat (4) run_frame(0, 0);

    apply_settings(6, 4, 5, 5, 1'b0, REP_INFINITE);      // dropped updates
    run_frame(1, 0);
    run_frame(2, 3);
    run_frame(3, 0);
    run_frame(3, 11);

    repeat (FRAME_LIMIT) @(posedge CLK);
    #DRIVE_DELAY;
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d expected words never came out", exp_q.size());
    end
    $display("frames %0d, checks %0d, errors %0d", frames, checks, errors);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== sources.f ====
+incdir+test
verilog/stm_pkg.sv
verilog/stm_timer.sv
verilog/stm_segment_ctrl.sv
verilog/stm_pattern_ram.sv
verilog/stm_pattern_reader.sv
verilog/drive_fifo.sv
verilog/output_mask.sv
verilog/stm_top.sv
test/tb_stm.sv
